/* Bender.yml */
package:
  name: dmm_tx

sources:
  - dmm_tx_pkg.sv
  - dmm_tx_wr_ctrl.sv
  - dmm_tx_chn_track.sv
  - dmm_tx_buf_ram.sv
  - dmm_tx_frame_rd.sv
  - dmm_tx_top.sv
  - target: test
    files:
      - tb_dmm_tx.sv

/* dmm_tx_buf_ram.sv */
`timescale 1ns/1ns

module dmm_tx_buf_ram (
    input  logic                  clk_12_5m,
    input  logic                  we,
    input  dmm_tx_pkg::buf_addr_t waddr,
    input  dmm_tx_pkg::word_t     wdata,
    input  dmm_tx_pkg::buf_addr_t raddr,
    output dmm_tx_pkg::word_t     rdata
);

    localparam int DEPTH = dmm_tx_pkg::NUM_CHN * dmm_tx_pkg::REGION_WORDS;

    // 16 regions of 64 words
    dmm_tx_pkg::word_t mem [DEPTH];

    // write port
    always_ff @(posedge clk_12_5m) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // read port, one cycle latency
    always_ff @(posedge clk_12_5m) begin
        rdata <= mem[raddr];
    end

endmodule

/* dmm_tx_chn_track.sv */
`timescale 1ns/1ns

module dmm_tx_chn_track (
    input  logic                  clk_12_5m,
    input  logic                  rst_12_5m,
    input  logic                  wr_done,
    input  logic                  rd_last,
    input  dmm_tx_pkg::slot_cnt_t slot_cycles,
    output logic                  empty
);

    dmm_tx_pkg::slot_cnt_t dly_cnt;     // cycles to the next resend
    logic [1:0]            resend_cnt;
    logic                  resend;

    assign resend = (dly_cnt == dmm_tx_pkg::slot_cnt_t'(1));

    // ------------------------------------------------------------
    // resend timer
    // ------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            dly_cnt    <= '0;
            resend_cnt <= '0;
        end else if (wr_done) begin
            // fresh frame restarts the resend sequence
            dly_cnt    <= slot_cycles;
            resend_cnt <= '0;
        end else if (resend) begin
            resend_cnt <= resend_cnt + 2'd1;
            if (resend_cnt < dmm_tx_pkg::RESEND_MAX - 2'd1)
                dly_cnt <= slot_cycles;     // arm the next offer
            else
                dly_cnt <= '0;              // last resend, timer stops
        end else if (dly_cnt != '0) begin
            dly_cnt <= dly_cnt - 32'd1;
        end
    end

    // ------------------------------------------------------------
    // empty flag
    // ------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            empty <= 1'b1;
        end else if (rd_last) begin
            empty <= 1'b1;                  // frame drained
        end else if (wr_done || resend) begin
            empty <= 1'b0;
        end
    end

endmodule

/* dmm_tx_frame_rd.sv */
`timescale 1ns/1ns

module dmm_tx_frame_rd (
    input  logic                  clk_12_5m,
    input  logic                  rst_12_5m,
    input  dmm_tx_pkg::chn_vec_t  rd_en,
    input  dmm_tx_pkg::word_t     rdata,
    input  logic [7:0]            dst_sta_num,
    input  logic [2:0]            dst_box_num,
    input  logic [4:0]            chn_type,
    input  logic                  master_slave_flag,
    input  dmm_tx_pkg::payload_t  run_cycle,
    output dmm_tx_pkg::buf_addr_t raddr,
    output dmm_tx_pkg::chn_vec_t  rd_last,
    output dmm_tx_pkg::chn_vec_t  sdu_dval,
    output dmm_tx_pkg::word_t     sdu_data
);

    dmm_tx_pkg::rd_state_t state;
    dmm_tx_pkg::head_cnt_t head_cnt;
    dmm_tx_pkg::buf_addr_t rd_ptr;      // address of the word now on rdata
    dmm_tx_pkg::chn_idx_t  slot_num;
    dmm_tx_pkg::payload_t  pkt_len;
    dmm_tx_pkg::word_t     head_word;
    logic [2:0]            box_next;
    logic                  accept;
    logic                  in_head;

    assign accept   = (state != dmm_tx_pkg::RD_HOLD) && (|rd_en);
    assign in_head  = (state == dmm_tx_pkg::RD_IDLE) || (state == dmm_tx_pkg::RD_HEAD);
    assign box_next = dst_box_num + 3'd1;   // mod 8

    // one-hot request to slot number
    always_comb begin
        slot_num = '0;
        for (int i = 0; i < dmm_tx_pkg::NUM_CHN; i++) begin
            if (rd_en[i])
                slot_num = dmm_tx_pkg::chn_idx_t'(i);
        end
    end

    always_comb begin
        if (chn_type == dmm_tx_pkg::COM2_TYPE || chn_type == dmm_tx_pkg::COM3_TYPE)
            pkt_len = dmm_tx_pkg::COM_DATA_LEN - dmm_tx_pkg::HEAD_WORDS;
        else
            pkt_len = dmm_tx_pkg::IO_DATA_LEN - dmm_tx_pkg::HEAD_WORDS;
    end

    // ------------------------------------------------------------
    // header words
    // ------------------------------------------------------------
    always_comb begin
        case (head_cnt)
            3'd0:    head_word = {2'b10, 6'd0, dst_sta_num, box_next[2:1]};
            // 17-bit field, zero-extended into the word
            3'd1:    head_word = dmm_tx_pkg::word_t'({2'b00, box_next[0], slot_num,
                                                      7'd0, master_slave_flag, 2'b00});
            3'd3:    head_word = {2'b00, run_cycle};
            3'd4:    head_word = {2'b00, dmm_tx_pkg::DATA_TYPE};
            3'd6:    head_word = {2'b00, pkt_len};
            default: head_word = '0;            // words 2 and 5
        endcase
    end

    // ------------------------------------------------------------
    // read address, prefetched so rdata is ready at word 7
    // ------------------------------------------------------------
    always_comb begin
        if (accept && in_head && head_cnt == 3'd5)
            raddr = {slot_num, dmm_tx_pkg::region_off_t'(0)};     // region base
        else if (accept && state == dmm_tx_pkg::RD_PAYLOAD)
            raddr = {rd_ptr[9:6], rd_ptr[5:0] + 6'd1};           // wrap in region
        else
            raddr = rd_ptr;                                       // hold on pause
    end

    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m)
            rd_ptr <= '0;
        else
            rd_ptr <= raddr;
    end

    // ------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            state    <= dmm_tx_pkg::RD_IDLE;
            head_cnt <= '0;
            rd_last  <= '0;
        end else begin
            rd_last <= '0;
            case (state)
                dmm_tx_pkg::RD_IDLE, dmm_tx_pkg::RD_HEAD: begin
                    if (accept) begin
                        if (head_cnt == 3'd6) begin
                            state    <= dmm_tx_pkg::RD_PAYLOAD;
                            head_cnt <= '0;
                        end else begin
                            state    <= dmm_tx_pkg::RD_HEAD;
                            head_cnt <= head_cnt + 3'd1;
                        end
                    end
                end
                dmm_tx_pkg::RD_PAYLOAD: begin
                    if (accept && rdata[16]) begin  // end word goes out now
                        rd_last <= rd_en;
                        state   <= dmm_tx_pkg::RD_HOLD;
                    end
                end
                default: begin
                    if (rd_en == '0)
                        state <= dmm_tx_pkg::RD_IDLE;   // consumer let go
                end
            endcase
        end
    end

    // output word
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m)
            sdu_dval <= '0;
        else
            sdu_dval <= accept ? rd_en : '0;
    end

    always_ff @(posedge clk_12_5m) begin
        if (accept) begin
            if (in_head)
                sdu_data <= head_word;
            else
                sdu_data <= {1'b0, rdata[16:0]};    // no start flag on payload
        end
    end

endmodule

/* dmm_tx_pkg.sv */
package dmm_tx_pkg;

    // ------------------------------------------------------------
    // buffer geometry
    // ------------------------------------------------------------
    localparam int NUM_CHN      = 16;
    localparam int REGION_WORDS = 64;   // words per channel region
    localparam int ADDR_W       = 10;

    typedef logic [3:0]        chn_idx_t;
    typedef logic [15:0]       chn_vec_t;     // one bit per channel
    // region base is {chn, 6'd0}, so the channel sits in the upper 4 bits
    typedef logic [ADDR_W-1:0] buf_addr_t;
    typedef logic [5:0]        region_off_t;

    // bit 17 start of header, bit 16 end of frame
    typedef logic [17:0] word_t;
    typedef logic [15:0] payload_t;
    typedef logic [31:0] slot_cnt_t;
    typedef logic [2:0]  head_cnt_t;

    // ------------------------------------------------------------
    // header constants
    // ------------------------------------------------------------
    localparam logic [4:0] COM2_TYPE    = 5'd2;
    localparam logic [4:0] COM3_TYPE    = 5'd3;
    localparam payload_t   COM_DATA_LEN = 16'd128;
    localparam payload_t   IO_DATA_LEN  = 16'd64;
    localparam payload_t   HEAD_WORDS   = 16'd8;    // subtracted for packet length
    localparam payload_t   DATA_TYPE    = 16'h88b5;

    // ------------------------------------------------------------
    // send slot and resend
    // ------------------------------------------------------------
    localparam payload_t   SLOT_MIN_RUN = 16'd30;
    localparam slot_cnt_t  SLOT_DEFAULT = 32'd162500;  // used for short run cycles
    localparam slot_cnt_t  SLOT_SCALE   = 32'd5120;    // cycles per run_cycle unit
    localparam logic [1:0] RESEND_MAX   = 2'd2;

    // frame reader FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_HEAD,
        RD_PAYLOAD,
        RD_HOLD
    } rd_state_t;

endpackage

/* dmm_tx_top.sv */
`timescale 1ns/1ns

module dmm_tx_top (
    input  logic                  clk_12_5m,
    input  logic                  rst_12_5m,
    // write port
    input  logic                  wr_sel,
    input  dmm_tx_pkg::chn_idx_t  chn_sel,
    input  logic                  wr_en,
    input  dmm_tx_pkg::word_t     wr_data,
    // read port
    input  dmm_tx_pkg::chn_vec_t  rd_en,
    // box configuration
    input  dmm_tx_pkg::payload_t  run_cycle,
    input  logic [7:0]            dst_sta_num,
    input  logic [2:0]            dst_box_num,
    input  logic [4:0]            chn_type,
    input  logic                  master_slave_flag,
    output dmm_tx_pkg::chn_vec_t  dmm_empty,
    output dmm_tx_pkg::chn_vec_t  sdu_dval,
    output dmm_tx_pkg::word_t     sdu_data
);

    logic                  buf_we;
    dmm_tx_pkg::buf_addr_t buf_waddr;
    dmm_tx_pkg::word_t     buf_wdata;
    dmm_tx_pkg::buf_addr_t buf_raddr;
    dmm_tx_pkg::word_t     buf_rdata;
    dmm_tx_pkg::chn_vec_t  wr_done;
    dmm_tx_pkg::chn_vec_t  rd_last;
    dmm_tx_pkg::slot_cnt_t slot_cycles;

    dmm_tx_wr_ctrl u_wr_ctrl (
        .clk_12_5m   (clk_12_5m),
        .rst_12_5m   (rst_12_5m),
        .wr_sel      (wr_sel),
        .chn_sel     (chn_sel),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .run_cycle   (run_cycle),
        .buf_we      (buf_we),
        .buf_waddr   (buf_waddr),
        .buf_wdata   (buf_wdata),
        .wr_done     (wr_done),
        .slot_cycles (slot_cycles)
    );

    dmm_tx_buf_ram u_buf_ram (
        .clk_12_5m (clk_12_5m),
        .we        (buf_we),
        .waddr     (buf_waddr),
        .wdata     (buf_wdata),
        .raddr     (buf_raddr),
        .rdata     (buf_rdata)
    );

    // ------------------------------------------------------------
    // one tracker per channel
    // ------------------------------------------------------------
    for (genvar c = 0; c < dmm_tx_pkg::NUM_CHN; c++) begin : g_chn
        dmm_tx_chn_track u_track (
            .clk_12_5m   (clk_12_5m),
            .rst_12_5m   (rst_12_5m),
            .wr_done     (wr_done[c]),
            .rd_last     (rd_last[c]),
            .slot_cycles (slot_cycles),
            .empty       (dmm_empty[c])
        );
    end

    dmm_tx_frame_rd u_frame_rd (
        .clk_12_5m         (clk_12_5m),
        .rst_12_5m         (rst_12_5m),
        .rd_en             (rd_en),
        .rdata             (buf_rdata),
        .dst_sta_num       (dst_sta_num),
        .dst_box_num       (dst_box_num),
        .chn_type          (chn_type),
        .master_slave_flag (master_slave_flag),
        .run_cycle         (run_cycle),
        .raddr             (buf_raddr),
        .rd_last           (rd_last),
        .sdu_dval          (sdu_dval),
        .sdu_data          (sdu_data)
    );

endmodule

/* dmm_tx_wr_ctrl.sv */
`timescale 1ns/1ns

module dmm_tx_wr_ctrl (
    input  logic                   clk_12_5m,
    input  logic                   rst_12_5m,
    input  logic                   wr_sel,
    input  dmm_tx_pkg::chn_idx_t   chn_sel,
    input  logic                   wr_en,
    input  dmm_tx_pkg::word_t      wr_data,
    input  dmm_tx_pkg::payload_t   run_cycle,
    output logic                   buf_we,
    output dmm_tx_pkg::buf_addr_t  buf_waddr,
    output dmm_tx_pkg::word_t      buf_wdata,
    output dmm_tx_pkg::chn_vec_t   wr_done,
    output dmm_tx_pkg::slot_cnt_t  slot_cycles
);

    logic                    wr_sel_d1;
    logic                    wr_sel_d2;
    logic                    wr_en_d1;
    dmm_tx_pkg::chn_idx_t    chn_sel_d1;
    dmm_tx_pkg::word_t       wr_data_d1;
    dmm_tx_pkg::chn_idx_t    wr_chn;        // channel of the current frame
    dmm_tx_pkg::region_off_t wr_off;
    logic                    wr_sop;
    logic                    wr_eop;

    // ------------------------------------------------------------
    // input stage
    // ------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            wr_sel_d1 <= 1'b0;
            wr_sel_d2 <= 1'b0;
            wr_en_d1  <= 1'b0;
        end else begin
            wr_sel_d1 <= wr_sel;
            wr_sel_d2 <= wr_sel_d1;
            wr_en_d1  <= wr_en;
        end
    end

    always_ff @(posedge clk_12_5m) begin
        chn_sel_d1 <= chn_sel;
        wr_data_d1 <= wr_data;
        buf_wdata  <= wr_data_d1;   // lines up with buf_we
    end

    assign wr_sop = wr_sel_d1 & ~wr_sel_d2;
    assign wr_eop = ~wr_sel_d1 & wr_sel_d2;

    // ------------------------------------------------------------
    // write addressing
    // ------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            buf_we <= 1'b0;
            wr_chn <= '0;
            wr_off <= '0;
        end else begin
            buf_we <= wr_sel_d1 & wr_en_d1;
            if (wr_sop) begin
                wr_chn <= chn_sel_d1;
                wr_off <= '0;
            end else if (buf_we) begin
                wr_off <= wr_off + 6'd1;    // wraps inside the region
            end
        end
    end

    assign buf_waddr = {wr_chn, wr_off};

    // done pulse and send slot length
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            wr_done     <= '0;
            slot_cycles <= dmm_tx_pkg::SLOT_DEFAULT;
        end else begin
            wr_done <= wr_eop ? (dmm_tx_pkg::chn_vec_t'(1) << wr_chn) : '0;
            if (run_cycle > dmm_tx_pkg::SLOT_MIN_RUN)
                slot_cycles <= dmm_tx_pkg::slot_cnt_t'(run_cycle) * dmm_tx_pkg::SLOT_SCALE;
            else
                slot_cycles <= dmm_tx_pkg::SLOT_DEFAULT;
        end
    end

endmodule

/* tb.f */
dmm_tx_pkg.sv
dmm_tx_wr_ctrl.sv
dmm_tx_chn_track.sv
dmm_tx_buf_ram.sv
dmm_tx_frame_rd.sv
dmm_tx_top.sv
tb_dmm_tx.sv

/* tb_dmm_tx.sv */
`timescale 1ns/1ns

module tb_dmm_tx;

    localparam int RESEND_SLOT    = 31 * 5120;              // slot at run_cycle 31
    localparam int TIMEOUT_CYCLES = 3 * RESEND_SLOT + 20000;

    logic        clk_12_5m;
    logic        rst_12_5m;
    logic        wr_sel;
    logic [3:0]  chn_sel;
    logic        wr_en;
    logic [17:0] wr_data;
    logic [15:0] rd_en;
    logic [15:0] run_cycle;
    logic [7:0]  dst_sta_num;
    logic [2:0]  dst_box_num;
    logic [4:0]  chn_type;
    logic        master_slave_flag;
    logic [15:0] dmm_empty;
    logic [15:0] sdu_dval;
    logic [17:0] sdu_data;

    logic [31:0] lfsr_state = 32'hfe0f;
    int          cycle_cnt  = 0;
    int          check_cnt  = 0;
    int          err_cnt    = 0;
    int          test_err_base = 0;
    logic [17:0] sent_q[$];     // words given to the write port
    logic [17:0] recv_q[$];     // words seen on sdu_data

    dmm_tx_top uut (.*);

    always #100 clk_12_5m = ~clk_12_5m;

    always @(posedge clk_12_5m) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles before the tests finished", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    // taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic        fb;
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("ERROR: %s", msg);
    endtask

    task automatic wait_empty(input int ch, input logic level, input int limit,
                              output int waited);
        waited = 0;
        while (dmm_empty[ch] !== level && waited < limit) begin
            @(negedge clk_12_5m);
            waited++;
        end
        if (dmm_empty[ch] !== level)
            report_error($sformatf("dmm_empty[%0d] did not go to %0b within %0d cycles",
                                   ch, level, limit));
    endtask

    task automatic write_frame(input int ch, input int n);
        logic [31:0] r;
        int          waited;
        sent_q.delete();
        @(negedge clk_12_5m);
        wr_sel  = 1'b1;
        chn_sel = ch[3:0];
        for (int i = 0; i < n; i++) begin
            r = rand_bits(1);
            if (r[0]) begin
                @(negedge clk_12_5m);
                wr_en = 1'b0;               // idle cycle inside the frame
            end
            r = rand_bits(17);
            @(negedge clk_12_5m);
            wr_en   = 1'b1;
            wr_data = {r[16], (i == n - 1), r[15:0]};   // eof on the last word
            sent_q.push_back(wr_data);
        end
        @(negedge clk_12_5m);
        wr_en  = 1'b0;
        wr_sel = 1'b0;
        wait_empty(ch, 1'b0, 10, waited);
    endtask

    task automatic read_frame(input int ch);
        int   cycles;
        int   waited;
        logic started;
        logic done;
        recv_q.delete();
        started = 1'b0;
        done    = 1'b0;
        cycles  = 0;
        @(negedge clk_12_5m);
        rd_en = 16'd1 << ch;
        while (!done && cycles < 200) begin
            @(negedge clk_12_5m);
            cycles++;
            if (sdu_dval != '0) begin
                started = 1'b1;
                check_val("sdu_dval", sdu_dval, 32'd1 << ch);
                recv_q.push_back(sdu_data);
                if (recv_q.size() > 7 && sdu_data[16])
                    done = 1'b1;
            end else if (started) begin
                report_error($sformatf("gap in the output of channel %0d", ch));
                done = 1'b1;
            end
        end
        rd_en = '0;
        if (!done)
            report_error($sformatf("channel %0d sent no end word", ch));
        wait_empty(ch, 1'b1, 5, waited);
    endtask

    // header and payload against the rules of the frame format
    task automatic check_frame(input int ch);
        logic [2:0]  box_next;
        logic [15:0] pkt_len;
        box_next = dst_box_num + 3'd1;
        pkt_len  = (chn_type == 5'd2 || chn_type == 5'd3) ? 16'd120 : 16'd56;
        check_val("frame length", recv_q.size(), 7 + sent_q.size());
        if (recv_q.size() == 7 + sent_q.size()) begin
            check_val("sdu_data word 0", recv_q[0], {2'b10, 6'd0, dst_sta_num, box_next[2:1]});
            check_val("sdu_data word 1", recv_q[1], (32'(box_next[0]) << 14) |
                      (32'(ch) << 10) | (32'(master_slave_flag) << 2));
            check_val("sdu_data word 2", recv_q[2], 0);
            check_val("sdu_data word 3", recv_q[3], run_cycle);
            check_val("sdu_data word 4", recv_q[4], 32'h88b5);
            check_val("sdu_data word 5", recv_q[5], 0);
            check_val("sdu_data word 6", recv_q[6], pkt_len);
            foreach (sent_q[i])
                check_val($sformatf("sdu_data payload %0d", i), recv_q[7 + i],
                          {1'b0, sent_q[i][16:0]});
        end
    endtask

    task automatic report_test(input string name);
        $display("%-28s %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic reset_values();
        check_val("dmm_empty", dmm_empty, 16'hffff);
        check_val("sdu_dval", sdu_dval, 0);
        report_test("reset state");
    endtask

    task automatic single_frame();
        write_frame(5, 9);
        check_val("dmm_empty", dmm_empty, 16'hffdf);
        read_frame(5);
        check_frame(5);
        check_val("dmm_empty", dmm_empty, 16'hffff);
        report_test("single frame on channel 5");
    endtask

    task automatic pkt_len_by_type();
        dst_box_num       = 3'd7;           // box_next wraps to 0
        master_slave_flag = 1'b0;
        for (int i = 0; i < 3; i++) begin
            chn_type = (i == 0) ? 5'd2 : (i == 1) ? 5'd3 : 5'd17;
            write_frame(2, 4);
            read_frame(2);
            check_frame(2);
        end
        report_test("packet length by type");
    endtask

    task automatic region_split();
        logic [17:0] frame0[$];
        write_frame(0, 12);
        frame0 = sent_q;
        write_frame(15, 20);
        check_val("dmm_empty", dmm_empty, 16'h7ffe);
        read_frame(15);
        check_frame(15);
        sent_q = frame0;                    // channel 0 read back last
        read_frame(0);
        check_frame(0);
        report_test("regions 0 and 15");
    endtask

    task automatic resend_twice();
        int   waited;
        logic extra;
        extra     = 1'b0;
        run_cycle = 16'd31;
        repeat (2) @(negedge clk_12_5m);    // slot length register follows
        write_frame(9, 6);
        read_frame(9);
        check_frame(9);
        for (int r = 1; r <= 2; r++) begin
            wait_empty(9, 1'b0, RESEND_SLOT + 500, waited);
            if (waited < RESEND_SLOT - 500)
                report_error($sformatf("resend %0d came after only %0d cycles", r, waited));
            read_frame(9);
            check_frame(9);
        end
        repeat (RESEND_SLOT + 1000) begin
            @(negedge clk_12_5m);
            if (!dmm_empty[9])
                extra = 1'b1;
        end
        if (extra)
            report_error("channel 9 offered its frame a third time");
        report_test("resend twice on channel 9");
    endtask

    initial begin
        clk_12_5m         = 1'b0;
        rst_12_5m         = 1'b0;
        wr_sel            = 1'b0;
        chn_sel           = '0;
        wr_en             = 1'b0;
        wr_data           = '0;
        rd_en             = '0;
        run_cycle         = 16'd20;         // default slot
        dst_sta_num       = 8'h5a;
        dst_box_num       = 3'd2;           // box_next 3 sets bit 0
        chn_type          = 5'd2;
        master_slave_flag = 1'b1;
        repeat (5) @(negedge clk_12_5m);
        rst_12_5m = 1'b1;
        @(negedge clk_12_5m);

        reset_values();
        single_frame();
        pkt_len_by_type();
        region_split();
        resend_twice();

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
